//--- Makefile
# Verilator build and run for the victim queue testbench

TOP := tb_victim_queue

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f vlog.f --top-module $(TOP)

# The run fails unless the simulation output holds the pass message
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

//--- dv/tb_victim_queue.sv
/*
 * Victim queue testbench
 * Replays the operation vectors and checks lookups, writebacks and credit returns
 */
`timescale 1ns/1ps
`default_nettype none

module tb_victim_queue import vq_pkg::*; ();

    localparam int          CLK_PERIOD   = 8;
    localparam int          RESET_CYCLES = 16;
    localparam int unsigned SEED         = 32'h0d5a6a43;
    localparam int          WAIT_LIMIT   = 100;
    localparam int          DRAIN_LIMIT  = 200;
    localparam int          MAX_VECTORS  = 64;

    localparam logic [3:0] OP_VICTIM = 4'h1;
    localparam logic [3:0] OP_LOOKUP = 4'h2;
    localparam logic [3:0] OP_CREDIT = 4'h3;
    localparam logic [3:0] OP_END    = 4'hF;

    // One record of the vector file with fields in file column order
    typedef struct packed {
        logic [3:0]            op;
        logic [ADDR_W-1:0]     addr;
        logic [DATA_BYTES-1:0] sel;
        logic [3:0]            hit;
        logic [DATA_W-1:0]     word;
        logic [LINE_W-1:0]     line;
    } vector_t;

    localparam int VEC_W = $bits(vector_t);

    logic         i_clk;
    logic         i_rst;
    logic         i_victim_valid;
    victim_t      i_victim;
    logic         o_victim_credit;
    logic         i_lookup_valid;
    lookup_req_t  i_lookup;
    lookup_resp_t o_lookup_resp;
    logic         i_mem_credit;
    logic         o_wb_valid;
    wb_req_t      o_wb;

    logic [VEC_W-1:0] vectors [MAX_VECTORS];
    lookup_resp_t     drv_exp_resp;
    wb_req_t          exp_wb_q [$];
    int               victim_credits;
    int               mem_outstanding;
    int               stored_victims;
    int               lookup_errors;
    int               wb_errors;
    int               flag_errors;
    int               protocol_errors;
    int               timeouts;
    logic             mon_lookup_pending;
    lookup_resp_t     mon_exp_resp;
    logic             mon_prev_wb;
    logic             exp_wb_valid;

    victim_queue UUT (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_victim_valid  (i_victim_valid),
        .i_victim        (i_victim),
        .o_victim_credit (o_victim_credit),
        .i_lookup_valid  (i_lookup_valid),
        .i_lookup        (i_lookup),
        .o_lookup_resp   (o_lookup_resp),
        .i_mem_credit    (i_mem_credit),
        .o_wb_valid      (o_wb_valid),
        .o_wb            (o_wb)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    task automatic check_lookup(input lookup_resp_t got, input lookup_resp_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED: o_lookup_resp hit=%h data=%h, expected hit=%h data=%h",
                     got.hit, got.data, exp.hit, exp.data);
            lookup_errors++;
        end
    endtask

    task automatic check_wb(input wb_req_t got, input wb_req_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED: o_wb addr=%h line=%h, expected addr=%h line=%h",
                     got.addr, got.line, exp.addr, exp.line);
            wb_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED: %s=%h, expected %h", name, got, exp);
            flag_errors++;
        end
    endtask

    // Controls for the next clock edge are set right after the falling edge
    task automatic drive_cycle(input logic victim_valid, input logic lookup_valid,
                               input logic mem_credit);
        @(negedge i_clk);
        i_victim_valid = victim_valid;
        i_lookup_valid = lookup_valid;
        i_mem_credit   = mem_credit;
    endtask

    task automatic drive_idle();
        drive_cycle(1'b0, 1'b0, 1'b0);
    endtask

    task automatic apply_vector(input vector_t rec);
        int waited;
        case (rec.op)
            OP_VICTIM: begin
                waited = 0;
                while (victim_credits == 0 && waited < WAIT_LIMIT) begin
                    drive_idle();
                    waited++;
                end
                if (victim_credits == 0) begin
                    $display("ERROR: no victim credit came back within %0d cycles", WAIT_LIMIT);
                    timeouts++;
                end else begin
                    drive_cycle(1'b1, 1'b0, 1'b0);
                    i_victim = '{addr: rec.addr, line: rec.line};
                    victim_credits--;
                    // Memory sees the line address with the offset cleared
                    exp_wb_q.push_back('{addr: {rec.addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}},
                                         line: rec.line});
                end
            end
            OP_LOOKUP: begin
                drive_cycle(1'b0, 1'b1, 1'b0);
                i_lookup     = '{addr: rec.addr, byte_sel: rec.sel};
                drv_exp_resp = '{hit: rec.hit[0], data: rec.word};
            end
            OP_CREDIT: drive_cycle(1'b0, 1'b0, 1'b1);
            default:   drive_idle();
        endcase
    endtask

    // Monitor sampling at the rising edge
    always @(posedge i_clk) begin
        if (i_rst) begin
            mon_lookup_pending = 1'b0;
            mon_prev_wb        = 1'b0;
            mem_outstanding    = 0;
            stored_victims     = 0;
        end else begin
            // Response belongs to the request taken at the previous edge
            if (mon_lookup_pending) begin
                check_lookup(o_lookup_resp, mon_exp_resp);
            end else begin
                check_lookup(o_lookup_resp, '0);
            end
            mon_lookup_pending = i_lookup_valid;
            mon_exp_resp       = drv_exp_resp;

            // A line leaves whenever one is held and memory has a credit to spare
            exp_wb_valid = (stored_victims > 0) && (mem_outstanding > 0);
            check_flag("o_wb_valid", o_wb_valid, exp_wb_valid);
            if (exp_wb_valid) begin
                check_wb(o_wb, exp_wb_q.pop_front());
                stored_victims--;
                mem_outstanding--;
            end

            check_flag("o_victim_credit", o_victim_credit, mon_prev_wb);
            mon_prev_wb = exp_wb_valid;
            if (o_victim_credit) begin
                victim_credits++;
            end
            if (victim_credits > VQ_DEPTH) begin
                $display("ERROR: cache holds more victim credits than the queue has slots");
                protocol_errors++;
            end

            if (i_victim_valid) begin
                stored_victims++;
            end
            if (i_mem_credit) begin
                mem_outstanding++;
            end
        end
    end

    initial begin
        vector_t rec;
        int      idx;
        int      waited;
        void'($urandom(SEED));
        i_rst          = 1'b1;
        i_victim_valid = 1'b0;
        i_victim       = '0;
        i_lookup_valid = 1'b0;
        i_lookup       = '0;
        i_mem_credit   = 1'b0;
        drv_exp_resp   = '0;
        victim_credits = VQ_DEPTH;
        lookup_errors   = 0;
        wb_errors       = 0;
        flag_errors     = 0;
        protocol_errors = 0;
        timeouts        = 0;
        for (idx = 0; idx < MAX_VECTORS; idx++) begin
            vectors[idx] = '1;
        end
        $readmemh("dv/vq_vectors.txt", vectors);

        repeat (RESET_CYCLES) @(negedge i_clk);
        i_rst = 1'b0;

        for (idx = 0; idx < MAX_VECTORS; idx++) begin
            rec = vector_t'(vectors[idx]);
            if (rec.op == OP_END || timeouts != 0) begin
                break;
            end
            repeat ($urandom_range(3, 0)) drive_idle();
            apply_vector(rec);
        end
        drive_idle();

        // Every victim written back and every cache credit home
        waited = 0;
        while ((exp_wb_q.size() != 0 || victim_credits != VQ_DEPTH) && waited < DRAIN_LIMIT) begin
            drive_idle();
            waited++;
        end
        if (exp_wb_q.size() != 0 || victim_credits != VQ_DEPTH) begin
            $display("ERROR: queue did not drain, %0d writebacks missing, %0d of %0d credits back",
                     exp_wb_q.size(), victim_credits, VQ_DEPTH);
            timeouts++;
        end
        repeat (2) drive_idle();

        $display("Errors: lookup %0d, writeback %0d, flag %0d, protocol %0d, timeout %0d",
                 lookup_errors, wb_errors, flag_errors, protocol_errors, timeouts);
        if (lookup_errors + wb_errors + flag_errors + protocol_errors + timeouts == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/vq_vectors.txt
// op (0 idle, 1 victim, 2 lookup, 3 memory credit, F end) _ address _ byte select
// _ expected hit _ expected word _ line data (byte 15 first)
0_00000000_0_0_00000000_00000000000000000000000000000000
2_10000040_F_0_00000000_00000000000000000000000000000000
1_10000047_0_0_00000000_AFAEADACABAAA9A8A7A6A5A4A3A2A1A0
2_10000040_F_1_A3A2A1A0_00000000000000000000000000000000
1_20000A35_0_0_00000000_BFBEBDBCBBBAB9B8B7B6B5B4B3B2B1B0
2_10000044_F_1_A7A6A5A4_00000000000000000000000000000000
2_20000A3D_F_1_00BFBEBD_00000000000000000000000000000000
1_00001100_0_0_00000000_CFCECDCCCBCAC9C8C7C6C5C4C3C2C1C0
1_DEADBEEF_0_0_00000000_DFDEDDDCDBDAD9D8D7D6D5D4D3D2D1D0
2_00001108_5_1_00CA00C8_00000000000000000000000000000000
2_DEADBEE2_A_1_D500D300_00000000000000000000000000000000
2_DEADBEF0_F_0_00000000_00000000000000000000000000000000
2_0000110F_F_1_000000CF_00000000000000000000000000000000
3_00000000_0_0_00000000_00000000000000000000000000000000
0_00000000_0_0_00000000_00000000000000000000000000000000
2_10000040_F_0_00000000_00000000000000000000000000000000
1_30000000_0_0_00000000_EFEEEDECEBEAE9E8E7E6E5E4E3E2E1E0
2_30000009_3_1_0000EAE9_00000000000000000000000000000000
2_20000A30_F_1_B3B2B1B0_00000000000000000000000000000000
3_00000000_0_0_00000000_00000000000000000000000000000000
3_00000000_0_0_00000000_00000000000000000000000000000000
3_00000000_0_0_00000000_00000000000000000000000000000000
3_00000000_0_0_00000000_00000000000000000000000000000000
0_00000000_0_0_00000000_00000000000000000000000000000000
2_30000000_F_0_00000000_00000000000000000000000000000000
1_40000010_0_0_00000000_4F4E4D4C4B4A49484746454443424140
1_50000024_0_0_00000000_5F5E5D5C5B5A59585756555453525150
1_6000003C_0_0_00000000_6F6E6D6C6B6A69686766656463626160
1_7000000A_0_0_00000000_7F7E7D7C7B7A79787776757473727170
2_6000003E_F_1_00006F6E_00000000000000000000000000000000
2_40000013_8_1_46000000_00000000000000000000000000000000
2_50000021_0_1_00000000_00000000000000000000000000000000
2_7000000C_F_1_7F7E7D7C_00000000000000000000000000000000
3_00000000_0_0_00000000_00000000000000000000000000000000
3_00000000_0_0_00000000_00000000000000000000000000000000
3_00000000_0_0_00000000_00000000000000000000000000000000
3_00000000_0_0_00000000_00000000000000000000000000000000
0_00000000_0_0_00000000_00000000000000000000000000000000
2_7000000C_F_0_00000000_00000000000000000000000000000000
F_00000000_0_0_00000000_00000000000000000000000000000000

//--- hw/victim_queue.sv
/*
 * Victim queue top level
 * Evicted data cache lines wait here for writeback and stay visible to loads
 */
`timescale 1ns/1ps
`default_nettype none

module victim_queue import vq_pkg::*; (
    input  wire logic   i_clk,
    input  wire logic   i_rst,

    // Victims from the data cache
    input  wire logic   i_victim_valid,
    input  victim_t     i_victim,
    output logic        o_victim_credit,

    // Load lookup
    input  wire logic   i_lookup_valid,
    input  lookup_req_t i_lookup,
    output lookup_resp_t o_lookup_resp,

    // Writeback to memory
    input  wire logic   i_mem_credit,
    output logic        o_wb_valid,
    output wb_req_t     o_wb
);

    logic [VQ_DEPTH-1:0] alloc_en;
    logic [TAG_W-1:0]    alloc_tag;
    logic [LINE_W-1:0]   alloc_line;
    logic [VQ_DEPTH-1:0] free_en;
    logic [TAG_W-1:0]    lookup_tag;
    logic [VQ_DEPTH-1:0] slot_hit;
    vq_slot_t            slots [VQ_DEPTH];

    vq_intake u_intake (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_victim_valid (i_victim_valid),
        .i_victim       (i_victim),
        .o_alloc_en     (alloc_en),
        .o_alloc_tag    (alloc_tag),
        .o_alloc_line   (alloc_line)
    );

    for (genvar i = 0; i < VQ_DEPTH; i++) begin : gen_slot
        vq_entry u_entry (
            .i_clk        (i_clk),
            .i_rst        (i_rst),
            .i_alloc_en   (alloc_en[i]),
            .i_alloc_tag  (alloc_tag),
            .i_alloc_line (alloc_line),
            .i_free_en    (free_en[i]),
            .i_lookup_tag (lookup_tag),
            .o_slot       (slots[i]),
            .o_hit        (slot_hit[i])
        );
    end

    vq_lookup u_lookup (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_lookup_valid (i_lookup_valid),
        .i_lookup       (i_lookup),
        .i_hit          (slot_hit),
        .i_slots        (slots),
        .o_lookup_tag   (lookup_tag),
        .o_lookup_resp  (o_lookup_resp)
    );

    vq_writeback u_writeback (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_mem_credit    (i_mem_credit),
        .i_slots         (slots),
        .o_free_en       (free_en),
        .o_wb_valid      (o_wb_valid),
        .o_wb            (o_wb),
        .o_victim_credit (o_victim_credit)
    );

endmodule

`default_nettype wire

//--- hw/vq_entry.sv
/*
 * Victim queue slot
 * Holds one evicted line and compares its tag against the lookup tag
 */
`timescale 1ns/1ps
`default_nettype none

module vq_entry import vq_pkg::*; (
    input  wire logic              i_clk,
    input  wire logic              i_rst,

    input  wire logic              i_alloc_en,
    input  wire logic [TAG_W-1:0]  i_alloc_tag,
    input  wire logic [LINE_W-1:0] i_alloc_line,

    input  wire logic              i_free_en,

    input  wire logic [TAG_W-1:0]  i_lookup_tag,
    output vq_slot_t               o_slot,
    output logic                   o_hit
);

    logic              slot_valid;
    logic [TAG_W-1:0]  slot_tag;
    logic [LINE_W-1:0] slot_line;

    // Allocate and free never land on the same slot in one edge
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            slot_valid <= 1'b0;
        end else if (i_alloc_en) begin
            slot_valid <= 1'b1;
        end else if (i_free_en) begin
            slot_valid <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_alloc_en) begin
            slot_tag  <= i_alloc_tag;
            slot_line <= i_alloc_line;
        end
    end

    assign o_slot = '{valid: slot_valid, tag: slot_tag, line: slot_line};

    // A stale tag in a freed slot must never hit
    assign o_hit = slot_valid && (slot_tag == i_lookup_tag);

endmodule

`default_nettype wire

//--- hw/vq_intake.sv
/*
 * Victim queue intake
 * Owns the tail pointer and steers each accepted victim into its slot
 */
`timescale 1ns/1ps
`default_nettype none

module vq_intake import vq_pkg::*; (
    input  wire logic              i_clk,
    input  wire logic              i_rst,

    input  wire logic              i_victim_valid,
    input  victim_t                i_victim,

    output logic [VQ_DEPTH-1:0]    o_alloc_en,
    output logic [TAG_W-1:0]       o_alloc_tag,
    output logic [LINE_W-1:0]      o_alloc_line
);

    logic [VQ_IDX_W-1:0] tail;
    logic [VQ_DEPTH-1:0] tail_onehot;

    // No full check here, the cache only sends while it holds a credit
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            tail <= '0;
        end else if (i_victim_valid) begin
            tail <= tail + 1'b1;
        end
    end

    // Tail pointer as a one-hot slot select
    always_comb begin
        tail_onehot = '0;
        tail_onehot[tail] = 1'b1;
    end

    assign o_alloc_en = i_victim_valid ? tail_onehot : '0;

    // Slots keep only the tag, the line offset is dropped
    assign o_alloc_tag  = i_victim.addr[ADDR_W-1:OFFSET_W];
    assign o_alloc_line = i_victim.line;

endmodule

`default_nettype wire

//--- hw/vq_lookup.sv
/*
 * Victim queue lookup
 * Associative search over the slots, byte-selected word extraction, registered response
 */
`timescale 1ns/1ps
`default_nettype none

module vq_lookup import vq_pkg::*; (
    input  wire logic              i_clk,
    input  wire logic              i_rst,

    input  wire logic              i_lookup_valid,
    input  lookup_req_t            i_lookup,

    input  wire logic [VQ_DEPTH-1:0] i_hit,
    input  vq_slot_t               i_slots [VQ_DEPTH],

    output logic [TAG_W-1:0]       o_lookup_tag,
    output lookup_resp_t           o_lookup_resp
);

    logic [OFFSET_W-1:0]      lookup_offset;
    logic [VQ_IDX_W-1:0]      hit_idx;
    logic [LINE_W+DATA_W-1:0] padded_line;
    logic [DATA_W-1:0]        word;
    logic                     hit_d;
    logic [DATA_W-1:0]        data_d;
    logic                     resp_hit;
    logic [DATA_W-1:0]        resp_data;

    assign o_lookup_tag  = i_lookup.addr[ADDR_W-1:OFFSET_W];
    assign lookup_offset = i_lookup.addr[OFFSET_W-1:0];

    // Encode the hit vector since at most one slot matches a given tag
    always_comb begin
        hit_idx = '0;
        for (int i = 0; i < VQ_DEPTH; i++) begin
            if (i_hit[i]) begin
                hit_idx = VQ_IDX_W'(i);
            end
        end
    end

    // Zero padding above the line so lanes past its end read as zero
    assign padded_line = {{DATA_W{1'b0}}, i_slots[hit_idx].line};

    // Byte j of the word comes from line byte offset+j when selected
    always_comb begin
        word = '0;
        for (int j = 0; j < DATA_BYTES; j++) begin
            if (i_lookup.byte_sel[j]) begin
                word[j*8 +: 8] = padded_line[(int'(lookup_offset) + j)*8 +: 8];
            end
        end
    end

    assign hit_d  = i_lookup_valid && (i_hit != '0);
    assign data_d = hit_d ? word : '0;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            resp_hit <= 1'b0;
        end else begin
            resp_hit <= hit_d;
        end
    end

    // Response word for the request taken at this edge
    always_ff @(posedge i_clk) begin
        resp_data <= data_d;
    end

    assign o_lookup_resp = '{hit: resp_hit, data: resp_data};

endmodule

`default_nettype wire

//--- hw/vq_pkg.sv
/*
 * Victim queue shared definitions
 * Slot array and cache line geometry, plus the payload structs of every channel
 */
`default_nettype none

package vq_pkg;

    // Queue geometry
    localparam int VQ_DEPTH     = 4;
    localparam int VQ_IDX_W     = $clog2(VQ_DEPTH);

    // Addressing and line layout
    localparam int ADDR_W       = 32;
    localparam int LINE_BYTES   = 16;
    localparam int LINE_W       = LINE_BYTES * 8;
    localparam int OFFSET_W     = $clog2(LINE_BYTES);
    localparam int TAG_W        = ADDR_W - OFFSET_W;

    // Load word returned by a lookup
    localparam int DATA_BYTES   = 4;
    localparam int DATA_W       = DATA_BYTES * 8;

    // Enough for the 7 credits memory may have outstanding
    localparam int MEM_CREDIT_W = 3;

    // Evicted line from the data cache, offset bits of addr are don't care
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [LINE_W-1:0] line;
    } victim_t;

    typedef struct packed {
        logic              valid;
        logic [TAG_W-1:0]  tag;
        logic [LINE_W-1:0] line;
    } vq_slot_t;

    typedef struct packed {
        logic [ADDR_W-1:0]     addr;
        logic [DATA_BYTES-1:0] byte_sel;
    } lookup_req_t;

    typedef struct packed {
        logic              hit;
        logic [DATA_W-1:0] data;
    } lookup_resp_t;

    // Writeback to memory, addr is always line aligned
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [LINE_W-1:0] line;
    } wb_req_t;

endpackage

`default_nettype wire

//--- hw/vq_writeback.sv
/*
 * Victim queue writeback
 * Drains the oldest slot to memory under memory credits and returns victim credits
 */
`timescale 1ns/1ps
`default_nettype none

module vq_writeback import vq_pkg::*; (
    input  wire logic              i_clk,
    input  wire logic              i_rst,

    input  wire logic              i_mem_credit,
    input  vq_slot_t               i_slots [VQ_DEPTH],

    output logic [VQ_DEPTH-1:0]    o_free_en,
    output logic                   o_wb_valid,
    output wb_req_t                o_wb,
    output logic                   o_victim_credit
);

    logic [VQ_IDX_W-1:0]     head;
    logic [VQ_DEPTH-1:0]     head_onehot;
    logic [MEM_CREDIT_W-1:0] mem_credits;
    vq_slot_t                head_slot;

    assign head_slot = i_slots[head];

    // Issue whenever the oldest line is present and memory can take it
    assign o_wb_valid = head_slot.valid && (mem_credits != '0);
    assign o_wb = '{addr: {head_slot.tag, {OFFSET_W{1'b0}}}, line: head_slot.line};

    always_comb begin
        head_onehot = '0;
        head_onehot[head] = 1'b1;
    end

    assign o_free_en = o_wb_valid ? head_onehot : '0;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            head <= '0;
        end else if (o_wb_valid) begin
            head <= head + 1'b1;
        end
    end

    // Credit in and issue may coincide and then cancel
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            mem_credits <= '0;
        end else begin
            case ({i_mem_credit, o_wb_valid})
                2'b10:   mem_credits <= mem_credits + 1'b1;
                2'b01:   mem_credits <= mem_credits - 1'b1;
                default: mem_credits <= mem_credits;
            endcase
        end
    end

    // One victim credit back to the cache per freed slot
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_victim_credit <= 1'b0;
        end else begin
            o_victim_credit <= o_wb_valid;
        end
    end

endmodule

`default_nettype wire

//--- vlog.f
hw/vq_pkg.sv
hw/vq_entry.sv
hw/vq_intake.sv
hw/vq_lookup.sv
hw/vq_writeback.sv
hw/victim_queue.sv
dv/tb_victim_queue.sv
